//--- dv/tb_clk_gen.sv
/*
 * tb_clk_gen
 * clock and active low reset for the testbench, reset released on a falling edge
 */
`timescale 1ns/1ps
`default_nettype none

module tb_clk_gen #(
    parameter int HALF_NS    = 4,   // 8 ns period
    parameter int RST_CYCLES = 16
) (
    output logic rst,   // clock
    output logic clk    // reset, active low
);

    initial begin
        rst = 1'b0;
        forever #HALF_NS rst = ~rst;
    end

    // release away from the rising edge
    initial begin
        clk = 1'b0;
        repeat (RST_CYCLES) @(posedge rst);
        @(negedge rst);
        clk = 1'b1;
    end

endmodule : tb_clk_gen

`default_nettype wire

//--- dv/tb_mcont_chnbuf.sv
/*
 * tb_mcont_chnbuf
 * table driven testbench for the readback path
 * LCG beat data and a per-channel page model that predicts
 * page counts and stored words
 */
`timescale 1ns/1ps
`default_nettype none

module tb_mcont_chnbuf
    import mcont_buf_pkg::*;
;

    localparam int NUM_CHN    = NUM_CHN_DFLT;
    localparam int PAGE_AW    = PAGE_AW_DFLT;
    localparam int WORD_AW    = WORD_AW_DFLT;
    localparam int PAGE_WORDS = 2 ** WORD_AW;
    localparam int NUM_PAGES  = 2 ** PAGE_AW;
    localparam int CHN_WORDS  = NUM_PAGES * PAGE_WORDS;
    localparam int IDLE_TMO   = 200;   // cycles per wait for busy low
    localparam logic [31:0] LCG_SEED = 32'hc26c_8914;

    // gap bit b holds rd_valid low before beat b
    typedef struct packed {
        logic [3:0]  chn;
        logic        refr;
        logic        poke;     // extra start that lands while busy
        logic [4:0]  nwords;
        logic [15:0] gap;
    } row_t;

    localparam int NROWS = 14;
    localparam row_t ROWS [NROWS] = '{
        '{4'd0, 1'b0, 1'b1, 5'd8,  16'h0000},
        '{4'd1, 1'b0, 1'b0, 5'd16, 16'h0000},
        '{4'd2, 1'b1, 1'b0, 5'd12, 16'h0000},   // refresh
        '{4'd3, 1'b0, 1'b0, 5'd5,  16'h0015},
        '{4'd0, 1'b1, 1'b1, 5'd16, 16'h00ff},   // refresh with gaps
        '{4'd2, 1'b0, 1'b0, 5'd4,  16'h0000},   // ch2 fills all pages
        '{4'd2, 1'b0, 1'b0, 5'd7,  16'h0042},
        '{4'd2, 1'b0, 1'b0, 5'd16, 16'h8001},
        '{4'd2, 1'b0, 1'b0, 5'd3,  16'h0000},
        '{4'd2, 1'b0, 1'b1, 5'd9,  16'h01f0},   // wraps onto page 0
        '{4'd1, 1'b0, 1'b1, 5'd6,  16'h002a},
        '{4'd0, 1'b0, 1'b0, 5'd1,  16'h0000},
        '{4'd2, 1'b1, 1'b0, 5'd4,  16'h0003},   // refresh over a written page
        '{4'd2, 1'b0, 1'b0, 5'd16, 16'hffff}    // gap before every beat
    };

    logic    rst;   // clock
    logic    clk;   // active low reset
    logic    cmd_start;
    chn_id_t cmd_chn;
    logic    cmd_refresh;
    cnt_t    cmd_nwords;
    logic    rd_valid;
    data_t   rd_data;
    chn_id_t rd_chn;
    logic [PAGE_AW-1:0] rd_page;
    logic [WORD_AW-1:0] rd_word;
    logic    busy;
    data_t   host_rdata;
    logic [NUM_CHN*PCNT_W-1:0] page_cnt_all;

    // model state
    data_t m_mem   [NUM_CHN][CHN_WORDS];
    bit    m_valid [NUM_CHN][CHN_WORDS];   // word written at least once
    int    m_page  [NUM_CHN];
    int    m_word  [NUM_CHN];
    int    m_pcnt  [NUM_CHN];

    logic [31:0] lcg_state;
    int checks;
    int errors;
    int n_tests;
    int n_failed;
    bit hung;

    tb_clk_gen u_clk_gen (.rst(rst), .clk(clk));

    mcont_chnbuf_top #(
        .NUM_CHN (NUM_CHN),
        .PAGE_AW (PAGE_AW),
        .WORD_AW (WORD_AW)
    ) i_dut (
        .rst          (rst),
        .clk          (clk),
        .cmd_start    (cmd_start),
        .cmd_chn      (cmd_chn),
        .cmd_refresh  (cmd_refresh),
        .cmd_nwords   (cmd_nwords),
        .rd_valid     (rd_valid),
        .rd_data      (rd_data),
        .rd_chn       (rd_chn),
        .rd_page      (rd_page),
        .rd_word      (rd_word),
        .busy         (busy),
        .host_rdata   (host_rdata),
        .page_cnt_all (page_cnt_all)
    );

    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    task automatic check_val(input logic [63:0] got, input logic [63:0] exp,
                             input string what);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("ERR %0t ns: %s, got %h expected %h", $time, what, got, exp);
        end
    endtask

    // two LCG steps per 64 bit beat
    task automatic next_beat(output data_t beat);
        lcg_state = lcg_next(lcg_state);
        beat[63:32] = lcg_state;
        lcg_state = lcg_next(lcg_state);
        beat[31:0] = lcg_state;
    endtask

    // data one cycle after the address
    task automatic host_read(input int chn, input int addr, output data_t data);
        @(posedge rst);
        rd_chn  <= chn_id_t'(chn);
        rd_page <= PAGE_AW'(addr / PAGE_WORDS);
        rd_word <= WORD_AW'(addr % PAGE_WORDS);
        @(posedge rst);
        @(negedge rst);
        data = host_rdata;
    endtask

    task automatic wait_idle(input int row);
        int n;
        for (n = 0; n < IDLE_TMO; n++) begin
            @(negedge rst);
            if (!busy) break;
        end
        if (busy) begin
            errors++;
            hung = 1'b1;
            $display("row %0d: busy still high after %0d cycles, sequencer hung", row, IDLE_TMO);
        end
    endtask

    // one command with its beats and the model update per beat
    task automatic run_row(input row_t row);
        int    b;
        int    c;
        data_t beat;
        c = int'(row.chn);
        @(posedge rst);
        cmd_start   <= 1'b1;
        cmd_chn     <= row.chn;
        cmd_refresh <= row.refr;
        cmd_nwords  <= row.nwords;
        @(posedge rst);
        cmd_start <= row.poke;            // lands while busy
        cmd_chn   <= row.chn + 4'd1;
        for (b = 0; b < int'(row.nwords); b++) begin
            if (row.gap[b]) begin
                rd_valid <= 1'b0;
                @(posedge rst);
                cmd_start <= 1'b0;
            end
            next_beat(beat);
            rd_valid <= 1'b1;
            rd_data  <= beat;
            if (!row.refr) begin
                m_mem[c][m_page[c] * PAGE_WORDS + m_word[c]]   = beat;
                m_valid[c][m_page[c] * PAGE_WORDS + m_word[c]] = 1'b1;
                m_word[c] = (m_word[c] + 1) % PAGE_WORDS;
            end
            @(posedge rst);
            cmd_start <= 1'b0;
        end
        rd_valid <= 1'b0;
        if (!row.refr) begin               // sequence end moves to next page
            m_page[c] = (m_page[c] + 1) % NUM_PAGES;
            m_word[c] = 0;
            m_pcnt[c] = (m_pcnt[c] + 1) % (2 ** PCNT_W);
        end
    endtask

    // page counts and every known word of all channels
    task automatic check_all();
        int    c;
        int    a;
        data_t got;
        @(negedge rst);
        for (c = 0; c < NUM_CHN; c++) begin
            check_val(64'(page_cnt_all[c*PCNT_W +: PCNT_W]), 64'(m_pcnt[c]),
                      $sformatf("page_cnt chn %0d", c));
        end
        for (c = 0; c < NUM_CHN; c++) begin
            for (a = 0; a < CHN_WORDS; a++) begin
                if (m_valid[c][a]) begin
                    host_read(c, a, got);
                    check_val(got, m_mem[c][a], $sformatf("chn %0d page %0d word %0d",
                              c, a / PAGE_WORDS, a % PAGE_WORDS));
                end
            end
        end
    endtask

    initial begin
        int r;
        int c;
        int a;
        int n;
        int errs_before;
        cmd_start   = 1'b0;
        cmd_chn     = '0;
        cmd_refresh = 1'b0;
        cmd_nwords  = '0;
        rd_valid    = 1'b0;
        rd_data     = '0;
        rd_chn      = '0;
        rd_page     = '0;
        rd_word     = '0;
        lcg_state   = LCG_SEED;
        checks      = 0;
        errors      = 0;
        n_tests     = 0;
        n_failed    = 0;
        hung        = 1'b0;
        for (c = 0; c < NUM_CHN; c++) begin
            m_page[c] = 0;
            m_word[c] = 0;
            m_pcnt[c] = 0;
            for (a = 0; a < CHN_WORDS; a++) begin
                m_mem[c][a]   = '0;
                m_valid[c][a] = 1'b0;
            end
        end

        // wait for reset release
        for (n = 0; n < 64; n++) begin
            @(negedge rst);
            if (clk) break;
        end
        if (!clk) begin
            errors++;
            hung = 1'b1;
            $display("reset never released, clock generator stuck");
        end else begin
            errs_before = errors;
            check_val(64'(busy), 64'd0, "busy after reset");
            check_all();
            n_tests++;
            if (errors != errs_before) n_failed++;
            $display("reset state: %s", (errors == errs_before) ? "ok" : "FAILED");
        end

        for (r = 0; r < NROWS && !hung; r++) begin
            errs_before = errors;
            run_row(ROWS[r]);
            wait_idle(r);
            if (!hung) begin
                repeat (2) @(posedge rst);   // page pulse reaches the buffers
                check_all();
            end
            n_tests++;
            if (errors != errs_before) n_failed++;
            $display("row %0d chn %0d %s nwords %0d: %s", r, ROWS[r].chn,
                     ROWS[r].refr ? "refresh" : "transfer", ROWS[r].nwords,
                     (errors == errs_before) ? "ok" : "FAILED");
        end

        $display("tests %0d, failed %0d, checks %0d, errors %0d",
                 n_tests, n_failed, checks, errors);
        if (errors == 0) begin
            $display("PASS: all tests");
        end else begin
            $display("FAIL: see errors above");
        end
        $finish;
    end

endmodule : tb_mcont_chnbuf

`default_nettype wire

//--- run_sim.sh
#!/usr/bin/env bash
# build the testbench with Verilator, run it, then look for the pass line in the log

cd "$(dirname "$0")" || exit 1

rm -rf obj_dir build.log sim.log

verilator --binary --timing \
    -f verilog.f \
    --top-module tb_mcont_chnbuf \
    -o sim_tb > build.log 2>&1 \
    || { echo "build failed, see build.log"; exit 1; }

./obj_dir/sim_tb > sim.log 2>&1 \
    || { echo "simulation did not run to the end, see sim.log"; exit 1; }

grep -qx "PASS: all tests" sim.log \
    && echo "simulation passed" \
    || { echo "simulation failed, see sim.log"; exit 1; }

//--- source/chn_page_buf.sv
/*
 * chn_page_buf
 * per-channel page memory, words fill the current page in order and
 * the next-page pulse moves on to the following page, host reads any word
 */
`timescale 1ns/1ps
`default_nettype none

module chn_page_buf
    import mcont_buf_pkg::*;
#(
    parameter int PAGE_AW = 2,
    parameter int WORD_AW = 4
) (
    input  wire logic               rst,             // clock
    input  wire logic               clk,             // async reset, active low
    input  wire logic               buf_wr_chn,      // from falling edge stage
    input  wire logic               buf_wpage_nxt_chn,
    input  wire data_t              buf_wdata_chn,
    input  wire logic [PAGE_AW-1:0] rd_page,
    input  wire logic [WORD_AW-1:0] rd_word,
    output data_t                   rd_data_chn,     // one cycle after address
    output logic [PCNT_W-1:0]       page_cnt         // completed pages, wraps
);

    localparam int MEM_DEPTH = 2 ** (PAGE_AW + WORD_AW);

    data_t mem [MEM_DEPTH];

    logic [PAGE_AW-1:0] wpage;   // page being filled
    logic [WORD_AW-1:0] wword;   // next word in that page

    // write pointers and page count
    always_ff @(posedge rst or negedge clk) begin
        if (!clk) begin
            wpage    <= '0;
            wword    <= '0;
            page_cnt <= '0;
        end else if (buf_wpage_nxt_chn) begin
            wpage    <= wpage + 1'b1;      // wraps, oldest page reused
            wword    <= '0;
            page_cnt <= page_cnt + 1'b1;
        end else if (buf_wr_chn) begin
            wword <= wword + 1'b1;         // no overflow check
        end
    end

    // storage
    always_ff @(posedge rst) begin
        if (buf_wr_chn) begin
            mem[{wpage, wword}] <= buf_wdata_chn;
        end
    end

    // host side, registered read
    always_ff @(posedge rst) begin
        rd_data_chn <= mem[{rd_page, rd_word}];
    end

endmodule : chn_page_buf

`default_nettype wire

//--- source/chnbuf_wr_reg.sv
/*
 * chnbuf_wr_reg
 * falling edge register stage, picks the beats of one channel off the
 * shared write bus and drops everything from refresh sequences
 */
`timescale 1ns/1ps
`default_nettype none

module chnbuf_wr_reg
    import mcont_buf_pkg::*;
#(
    parameter int CHN_NUMBER = 0
) (
    input  wire logic    rst,              // clock, falling edge used here
    input  wire logic    clk,              // async reset, active low
    ext_buf_wr_if.chn    wbus,
    output logic         buf_wr_chn,       // half cycle after wr
    output logic         buf_wpage_nxt_chn,
    output data_t        buf_wdata_chn
);

    logic chn_match;
    logic buf_chn_sel;   // pre-decoded half a cycle before the first wr

    assign chn_match = (wbus.wchn == CHN_W'(CHN_NUMBER));

    always_ff @(negedge rst or negedge clk) begin
        if (!clk) begin
            buf_chn_sel       <= 1'b0;
            buf_wr_chn        <= 1'b0;
            buf_wpage_nxt_chn <= 1'b0;
        end else begin
            buf_chn_sel <= chn_match && !wbus.wrefresh;
            buf_wr_chn  <= buf_chn_sel && wbus.wr;
            // page pulse qualified straight from the levels
            buf_wpage_nxt_chn <= wbus.wpage_nxt && chn_match && !wbus.wrefresh;
        end
    end

    // data captured only on a forwarded write
    always_ff @(negedge rst) begin
        if (buf_chn_sel && wbus.wr) begin
            buf_wdata_chn <= wbus.wdata;
        end
    end

endmodule : chnbuf_wr_reg

`default_nettype wire

//--- source/ext_buf_wr_if.sv
/*
 * ext_buf_wr_if
 * tagged write bus from the read sequencer, broadcast to all channel slices
 */
`timescale 1ns/1ps
`default_nettype none

interface ext_buf_wr_if
    import mcont_buf_pkg::*;
();

    logic    wr;         // beat strobe
    logic    wpage_nxt;  // single pulse, ends the sequence
    chn_id_t wchn;       // level, stable for the whole command
    logic    wrefresh;   // level, stable for the whole command
    data_t   wdata;      // valid with wr

    // sequencer side
    modport seq (
        output wr,
        output wpage_nxt,
        output wchn,
        output wrefresh,
        output wdata
    );

    // channel register side, every slice listens
    modport chn (
        input wr,
        input wpage_nxt,
        input wchn,
        input wrefresh,
        input wdata
    );

endinterface : ext_buf_wr_if

`default_nettype wire

//--- source/mcont_buf_pkg.sv
/*
 * mcont_buf_pkg
 * bus widths, default sizes and shared types for the readback path
 * from the memory controller into the per-channel page buffers
 */
`default_nettype none

package mcont_buf_pkg;

    // memory read beat and channel field
    localparam int DATA_W = 64;
    localparam int CHN_W  = 4;  // same channel field width as the controller

    // default sizes, the top level passes its own values down
    localparam int NUM_CHN_DFLT = 4;
    localparam int PAGE_AW_DFLT = 2;  // 4 pages
    localparam int WORD_AW_DFLT = 4;  // 16 words per page

    // completed page counter, wraps
    localparam int PCNT_W = 8;

    typedef logic [CHN_W-1:0]  chn_id_t;
    typedef logic [DATA_W-1:0] data_t;

    // one extra bit so a full page of words fits
    typedef logic [WORD_AW_DFLT:0] cnt_t;

endpackage : mcont_buf_pkg

`default_nettype wire

//--- source/mcont_chnbuf_top.sv
/*
 * mcont_chnbuf_top
 * read sequencer feeding NUM_CHN channel slices over one shared bus,
 * plus the host read port across all channel page buffers
 */
`timescale 1ns/1ps
`default_nettype none

module mcont_chnbuf_top
    import mcont_buf_pkg::*;
#(
    parameter int NUM_CHN = NUM_CHN_DFLT,
    parameter int PAGE_AW = PAGE_AW_DFLT,
    parameter int WORD_AW = WORD_AW_DFLT
) (
    input  wire logic                      rst,          // clock
    input  wire logic                      clk,          // async reset, active low
    input  wire logic                      cmd_start,
    input  wire chn_id_t                   cmd_chn,
    input  wire logic                      cmd_refresh,
    input  wire cnt_t                      cmd_nwords,
    input  wire logic                      rd_valid,
    input  wire data_t                     rd_data,
    input  wire chn_id_t                   rd_chn,
    input  wire logic [PAGE_AW-1:0]        rd_page,
    input  wire logic [WORD_AW-1:0]        rd_word,
    output logic                           busy,
    output data_t                          host_rdata,
    output logic [NUM_CHN*PCNT_W-1:0]      page_cnt_all  // channel 0 in low bits
);

    ext_buf_wr_if wbus ();

    data_t   rd_data_arr [NUM_CHN];  // per-slice read data
    chn_id_t rd_chn_q;               // lines up with buffer read latency

    mcont_read_seq u_read_seq (
        .rst         (rst),
        .clk         (clk),
        .cmd_start   (cmd_start),
        .cmd_chn     (cmd_chn),
        .cmd_refresh (cmd_refresh),
        .cmd_nwords  (cmd_nwords),
        .rd_valid    (rd_valid),
        .rd_data     (rd_data),
        .busy        (busy),
        .wbus        (wbus.seq)
    );

    // one register stage and one page buffer per channel
    for (genvar i = 0; i < NUM_CHN; i++) begin : g_chn
        logic  buf_wr_chn;
        logic  buf_wpage_nxt_chn;
        data_t buf_wdata_chn;

        chnbuf_wr_reg #(
            .CHN_NUMBER (i)
        ) u_wr_reg (
            .rst               (rst),
            .clk               (clk),
            .wbus              (wbus.chn),
            .buf_wr_chn        (buf_wr_chn),
            .buf_wpage_nxt_chn (buf_wpage_nxt_chn),
            .buf_wdata_chn     (buf_wdata_chn)
        );

        chn_page_buf #(
            .PAGE_AW (PAGE_AW),
            .WORD_AW (WORD_AW)
        ) u_page_buf (
            .rst               (rst),
            .clk               (clk),
            .buf_wr_chn        (buf_wr_chn),
            .buf_wpage_nxt_chn (buf_wpage_nxt_chn),
            .buf_wdata_chn     (buf_wdata_chn),
            .rd_page           (rd_page),
            .rd_word           (rd_word),
            .rd_data_chn       (rd_data_arr[i]),
            .page_cnt          (page_cnt_all[i*PCNT_W +: PCNT_W])
        );
    end

    always_ff @(posedge rst or negedge clk) begin
        if (!clk) begin
            rd_chn_q <= '0;
        end else begin
            rd_chn_q <= rd_chn;
        end
    end

    // read port mux, unknown channel reads as zero
    always_comb begin
        host_rdata = '0;
        for (int i = 0; i < NUM_CHN; i++) begin
            if (rd_chn_q == CHN_W'(i)) begin
                host_rdata = rd_data_arr[i];
            end
        end
    end

endmodule : mcont_chnbuf_top

`default_nettype wire

//--- source/mcont_read_seq.sv
/*
 * mcont_read_seq
 * accepts one transfer or refresh command at a time, tags the memory read
 * beats with channel and refresh flag and ends each sequence with a
 * next-page pulse on the shared write bus
 */
`timescale 1ns/1ps
`default_nettype none

module mcont_read_seq
    import mcont_buf_pkg::*;
(
    input  wire logic    rst,          // clock
    input  wire logic    clk,          // async reset, active low
    input  wire logic    cmd_start,    // ignored while busy
    input  wire chn_id_t cmd_chn,
    input  wire logic    cmd_refresh,
    input  wire cnt_t    cmd_nwords,
    input  wire logic    rd_valid,     // may have gaps, no stall allowed
    input  wire data_t   rd_data,
    output logic         busy,
    ext_buf_wr_if.seq    wbus
);

    cnt_t  nwords;      // latched word count
    cnt_t  beat_cnt;    // beats registered so far
    logic  cmd_accept;
    logic  beat_take;
    logic  seq_last;

    assign cmd_accept = cmd_start && !busy;

    // all beats in, waiting one cycle for the page pulse
    assign seq_last = busy && (beat_cnt == nwords);

    // beats past the word count are dropped
    assign beat_take = busy && rd_valid && (beat_cnt != nwords);

    // command state and channel/refresh levels
    always_ff @(posedge rst or negedge clk) begin
        if (!clk) begin
            busy          <= 1'b0;
            nwords        <= '0;
            wbus.wchn     <= '0;
            wbus.wrefresh <= 1'b0;
        end else if (cmd_accept) begin
            busy          <= 1'b1;
            nwords        <= cmd_nwords;
            wbus.wchn     <= cmd_chn;      // levels change only here
            wbus.wrefresh <= cmd_refresh;
        end else if (seq_last) begin
            busy <= 1'b0;                  // falls with wpage_nxt
        end
    end

    // beat counter
    always_ff @(posedge rst or negedge clk) begin
        if (!clk) begin
            beat_cnt <= '0;
        end else if (cmd_accept) begin
            beat_cnt <= '0;
        end else if (beat_take) begin
            beat_cnt <= beat_cnt + 1'b1;
        end
    end

    // strobes onto the bus, one cycle after the beat
    always_ff @(posedge rst or negedge clk) begin
        if (!clk) begin
            wbus.wr        <= 1'b0;
            wbus.wpage_nxt <= 1'b0;
        end else begin
            wbus.wr        <= beat_take;
            wbus.wpage_nxt <= seq_last;    // one cycle after the last wr
        end
    end

    // beat payload, only meaningful with wr
    always_ff @(posedge rst) begin
        if (beat_take) begin
            wbus.wdata <= rd_data;
        end
    end

endmodule : mcont_read_seq

`default_nettype wire

//--- verilog.f
source/mcont_buf_pkg.sv
source/ext_buf_wr_if.sv
source/mcont_read_seq.sv
source/chnbuf_wr_reg.sv
source/chn_page_buf.sv
source/mcont_chnbuf_top.sv
dv/tb_clk_gen.sv
dv/tb_mcont_chnbuf.sv
